//--- filelist.f
+incdir+source
+incdir+tb
source/support_pkg.sv
source/obi_phase_monitor.sv
source/req_attribute_queue.sv
source/retire_event_tracker.sv
source/support_logic_top.sv
tb/tb_support_logic.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the support logic testbench with Verilator and run it
# A nonzero exit status means the build or the simulation failed

cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps \
  -f filelist.f \
  --top-module tb_support_logic \
  -Mdir obj_dir &&
./obj_dir/Vtb_support_logic ||
{ echo "Build or simulation returned an error status"; exit 1; }

//--- source/obi_phase_monitor.sv
// OBI phase monitor
// Tracks address and response phases of one bus and counts transactions in flight
`timescale 1ns/1ps

module obi_phase_monitor
  import support_pkg::*;
(
  input  logic    in_support_if,
  input  logic    rst_i,
  input  logic    req_i,
  input  logic    gnt_i,
  input  logic    rvalid_i,
  output logic    addr_ph_cont_o,
  output logic    resp_ph_cont_o,
  output ph_cnt_t outstanding_o
);

  // Request was left waiting without grant last cycle
  logic    waiting_q;
  logic    accept;
  ph_cnt_t cnt_q;

  assign accept = req_i && gnt_i;

  // --------------------
  // Address phase
  // --------------------
  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      waiting_q <= 1'b0;
    end else begin
      waiting_q <= req_i && !gnt_i;
    end
  end

  assign addr_ph_cont_o = req_i && waiting_q;

  // --------------------
  // Response phase
  // --------------------
  // Up on accept, down on rvalid, both may happen together
  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      case ({accept, rvalid_i})
        2'b10:   cnt_q <= cnt_q + ph_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - ph_cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign outstanding_o = cnt_q;

  // A response is still awaited
  assign resp_ph_cont_o = (cnt_q != '0) && !rvalid_i;

endmodule : obi_phase_monitor

//--- source/req_attribute_queue.sv
// Request attribute queue
// Carries the attribute captured at grant to the matching in-order response
`timescale 1ns/1ps
`include "support_defines.svh"

module req_attribute_queue #(
  parameter type attr_t = logic
) (
  input  logic  in_support_if,
  input  logic  rst_i,
  input  logic  req_i,
  input  logic  gnt_i,
  input  logic  rvalid_i,
  input  attr_t attr_i,
  output attr_t resp_attr_o
);

  localparam int DEPTH = `SL_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  attr_t             mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              push;
  logic              pop;

  assign push = req_i && gnt_i;
  assign pop  = rvalid_i;

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem[wr_ptr_q] <= attr_i;
    end
  end

  // --------------------
  // Pointers and fill level
  // --------------------
  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Head entry shows in the rvalid cycle itself and reads zero when empty
  // No bypass is needed since a response never comes in its grant cycle
  assign resp_attr_o = (cnt_q != '0) ? mem[rd_ptr_q] : attr_t'('0);

endmodule : req_attribute_queue

//--- source/retire_event_tracker.sv
// Retirement event tracker
// Debug entry, start-up, held debug requests and saturating interrupt counts
`timescale 1ns/1ps
`include "support_defines.svh"

module retire_event_tracker
  import support_pkg::*;
(
  input  logic        in_support_if,
  input  logic        rst_i,
  input  logic        rvfi_valid_i,
  input  logic        rvfi_dbg_mode_i,
  input  logic        rvfi_is_dret_i,
  input  logic        rvfi_trap_i,
  input  logic        rvfi_intr_i,
  input  logic [10:0] rvfi_intr_cause_i,
  input  logic        fetch_enable_i,
  input  logic        debug_req_i,
  input  logic        irq_ack_i,
  output logic        first_debug_ins_o,
  output logic        first_fetch_o,
  output logic        recorded_dbg_req_o,
  output irq_cnt_t    cnt_irq_ack_o,
  output irq_cnt_t    cnt_rvfi_irqs_o
);

  logic       in_debug_q;
  logic       dret_q;
  logic       fetch_seen_q;
  // Retirements left before a recorded debug request is dropped
  logic [1:0] dbg_cnt_q;
  logic       count_irq;

  // --------------------
  // Debug entry
  // --------------------
  assign first_debug_ins_o = rvfi_valid_i && rvfi_dbg_mode_i && !in_debug_q;

  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      in_debug_q <= 1'b0;
      dret_q     <= 1'b0;
    end else begin
      if (rvfi_valid_i) begin
        in_debug_q <= rvfi_dbg_mode_i;
        if (rvfi_is_dret_i && !rvfi_trap_i) begin
          dret_q <= 1'b1;
        end
      end
      // Dret retired last cycle, next debug entry counts as first again
      if (dret_q) begin
        in_debug_q <= 1'b0;
        dret_q     <= 1'b0;
      end
    end
  end

  // --------------------
  // Core start-up
  // --------------------
  assign first_fetch_o = fetch_enable_i && !fetch_seen_q;

  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

  // --------------------
  // Debug request hold
  // --------------------
  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      recorded_dbg_req_o <= 1'b0;
      dbg_cnt_q          <= 2'd0;
    end else if (rvfi_valid_i) begin
      if (debug_req_i) begin
        recorded_dbg_req_o <= 1'b1;
        dbg_cnt_q          <= 2'd1;
      end else if (dbg_cnt_q != 2'd0) begin
        dbg_cnt_q <= dbg_cnt_q - 2'd1;
      end else begin
        recorded_dbg_req_o <= 1'b0;
      end
    end else if (debug_req_i) begin
      recorded_dbg_req_o <= 1'b1;
      dbg_cnt_q          <= 2'd2;
    end
  end

  // --------------------
  // Interrupt counters
  // --------------------
  assign count_irq = rvfi_valid_i && rvfi_intr_i &&
                     !(rvfi_intr_cause_i inside {[`SL_NMI_CAUSE_LO:`SL_NMI_CAUSE_HI]});

  always_ff @(posedge in_support_if) begin
    if (rst_i) begin
      cnt_irq_ack_o   <= '0;
      cnt_rvfi_irqs_o <= '0;
    end else begin
      if (irq_ack_i && (cnt_irq_ack_o != '1)) begin
        cnt_irq_ack_o <= cnt_irq_ack_o + irq_cnt_t'(1);
      end
      if (count_irq && (cnt_rvfi_irqs_o != '1)) begin
        cnt_rvfi_irqs_o <= cnt_rvfi_irqs_o + irq_cnt_t'(1);
      end
    end
  end

endmodule : retire_event_tracker

//--- source/support_defines.svh
// Support logic constants
// Queue depth, counter widths and the non-maskable interrupt cause range
`ifndef SUPPORT_DEFINES_SVH
`define SUPPORT_DEFINES_SVH

// --------------------
// Attribute queues
// --------------------
`define SL_QUEUE_DEPTH 4
// Most transactions in flight on one bus
`define SL_MAX_OUTSTANDING `SL_QUEUE_DEPTH

// --------------------
// Counters
// --------------------
`define SL_PH_CNT_W 3
`define SL_IRQ_CNT_W 8

// Causes in this range are NMIs and are not counted as retired interrupts
`define SL_NMI_CAUSE_LO 1024
`define SL_NMI_CAUSE_HI 1027

`endif

//--- source/support_logic_top.sv
// Support logic top
// Bus phase monitors, response attribute queues and retirement tracker
`timescale 1ns/1ps

module support_logic_top
  import support_pkg::*;
(
  input  logic        in_support_if,
  input  logic        rst_i,
  // Instruction bus
  input  logic        instr_req_i,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  addr_t       instr_req_pc_i,
  // Data bus
  input  logic        data_req_i,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  logic        data_req_is_store_i,
  input  logic        data_req_integrity_i,
  // Retirement and core control
  input  logic        rvfi_valid_i,
  input  logic        rvfi_dbg_mode_i,
  input  logic        rvfi_is_dret_i,
  input  logic        rvfi_trap_i,
  input  logic        rvfi_intr_i,
  input  logic [10:0] rvfi_intr_cause_i,
  input  logic        fetch_enable_i,
  input  logic        debug_req_i,
  input  logic        irq_ack_i,
  // Bus status
  output logic        instr_addr_ph_cont_o,
  output logic        instr_resp_ph_cont_o,
  output ph_cnt_t     instr_outstanding_o,
  output logic        data_addr_ph_cont_o,
  output logic        data_resp_ph_cont_o,
  output ph_cnt_t     data_outstanding_o,
  output addr_t       instr_resp_pc_o,
  output logic        data_resp_was_store_o,
  output logic        data_resp_had_integrity_o,
  // Retirement status
  output logic        first_debug_ins_o,
  output logic        first_fetch_o,
  output logic        recorded_dbg_req_o,
  output irq_cnt_t    cnt_irq_ack_o,
  output irq_cnt_t    cnt_rvfi_irqs_o
);

  data_attr_t data_req_attr;
  data_attr_t data_resp_attr;

  assign data_req_attr.is_store     = data_req_is_store_i;
  assign data_req_attr.integrity    = data_req_integrity_i;
  assign data_resp_was_store_o      = data_resp_attr.is_store;
  assign data_resp_had_integrity_o  = data_resp_attr.integrity;

  // --------------------
  // Instruction bus
  // --------------------
  obi_phase_monitor u_instr_phase (
    .in_support_if, .rst_i,
    .req_i(instr_req_i), .gnt_i(instr_gnt_i), .rvalid_i(instr_rvalid_i),
    .addr_ph_cont_o(instr_addr_ph_cont_o), .resp_ph_cont_o(instr_resp_ph_cont_o),
    .outstanding_o(instr_outstanding_o)
  );

  req_attribute_queue #(.attr_t(addr_t)) u_instr_pc_queue (
    .in_support_if, .rst_i,
    .req_i(instr_req_i), .gnt_i(instr_gnt_i), .rvalid_i(instr_rvalid_i),
    .attr_i(instr_req_pc_i), .resp_attr_o(instr_resp_pc_o)
  );

  // --------------------
  // Data bus
  // --------------------
  obi_phase_monitor u_data_phase (
    .in_support_if, .rst_i,
    .req_i(data_req_i), .gnt_i(data_gnt_i), .rvalid_i(data_rvalid_i),
    .addr_ph_cont_o(data_addr_ph_cont_o), .resp_ph_cont_o(data_resp_ph_cont_o),
    .outstanding_o(data_outstanding_o)
  );

  req_attribute_queue #(.attr_t(data_attr_t)) u_data_attr_queue (
    .in_support_if, .rst_i,
    .req_i(data_req_i), .gnt_i(data_gnt_i), .rvalid_i(data_rvalid_i),
    .attr_i(data_req_attr), .resp_attr_o(data_resp_attr)
  );

  // --------------------
  // Retirement
  // --------------------
  retire_event_tracker u_retire_tracker (
    .in_support_if, .rst_i,
    .rvfi_valid_i, .rvfi_dbg_mode_i, .rvfi_is_dret_i, .rvfi_trap_i,
    .rvfi_intr_i, .rvfi_intr_cause_i,
    .fetch_enable_i, .debug_req_i, .irq_ack_i,
    .first_debug_ins_o, .first_fetch_o, .recorded_dbg_req_o,
    .cnt_irq_ack_o, .cnt_rvfi_irqs_o
  );

endmodule : support_logic_top

//--- source/support_pkg.sv
// Support logic types
// Shared by the bus monitors, attribute queues and retirement tracker
`include "support_defines.svh"

package support_pkg;

  // PC of an instruction fetch
  typedef logic [31:0] addr_t;

  // Attributes of a data bus request
  typedef struct packed {
    logic is_store;
    logic integrity;
  } data_attr_t;

  // Transactions in flight on one bus
  typedef logic [`SL_PH_CNT_W-1:0] ph_cnt_t;

  // Saturating interrupt counter
  typedef logic [`SL_IRQ_CNT_W-1:0] irq_cnt_t;

endpackage : support_pkg

//--- tb/support_model.svh
// Support logic reference model
// Tracks expected bus queues and retirement status from the applied inputs

// --------------------
// Model state
// --------------------
addr_t pc_q[$];
logic  store_q[$];
logic  integ_q[$];
logic  instr_wait_m;
logic  data_wait_m;
logic  in_dbg_m;
logic  dret_pend_m;
logic  fetch_seen_m;
logic  rec_dbg_m;
// Retirements still tolerated before the debug request is dropped
int    dbg_left_m;
int    irq_ack_m;
int    rvfi_irq_m;

localparam int IRQ_MAX = (1 << `SL_IRQ_CNT_W) - 1;

task automatic reset_model();
  pc_q.delete();
  store_q.delete();
  integ_q.delete();
  instr_wait_m = 1'b0;
  data_wait_m  = 1'b0;
  in_dbg_m     = 1'b0;
  dret_pend_m  = 1'b0;
  fetch_seen_m = 1'b0;
  rec_dbg_m    = 1'b0;
  dbg_left_m   = 0;
  irq_ack_m    = 0;
  rvfi_irq_m   = 0;
endtask

// Compare every DUT output with the model in the current cycle
task automatic check_outputs();
  addr_t exp_pc;
  logic  exp_store;
  logic  exp_integ;
  exp_pc    = (pc_q.size() > 0) ? pc_q[0] : '0;
  exp_store = (store_q.size() > 0) ? store_q[0] : 1'b0;
  exp_integ = (integ_q.size() > 0) ? integ_q[0] : 1'b0;
  // Instruction bus
  check_value("instr_outstanding_o", 32'(pc_q.size()), 32'(instr_outstanding_o));
  check_value("instr_resp_ph_cont_o", 32'(pc_q.size() != 0 && !instr_rvalid_i),
              32'(instr_resp_ph_cont_o));
  check_value("instr_addr_ph_cont_o", 32'(instr_req_i && instr_wait_m),
              32'(instr_addr_ph_cont_o));
  check_value("instr_resp_pc_o", exp_pc, instr_resp_pc_o);
  // Data bus
  check_value("data_outstanding_o", 32'(store_q.size()), 32'(data_outstanding_o));
  check_value("data_resp_ph_cont_o", 32'(store_q.size() != 0 && !data_rvalid_i),
              32'(data_resp_ph_cont_o));
  check_value("data_addr_ph_cont_o", 32'(data_req_i && data_wait_m),
              32'(data_addr_ph_cont_o));
  check_value("data_resp_was_store_o", 32'(exp_store), 32'(data_resp_was_store_o));
  check_value("data_resp_had_integrity_o", 32'(exp_integ), 32'(data_resp_had_integrity_o));
  // Retirement status
  check_value("first_debug_ins_o", 32'(rvfi_valid_i && rvfi_dbg_mode_i && !in_dbg_m),
              32'(first_debug_ins_o));
  check_value("first_fetch_o", 32'(fetch_enable_i && !fetch_seen_m), 32'(first_fetch_o));
  check_value("recorded_dbg_req_o", 32'(rec_dbg_m), 32'(recorded_dbg_req_o));
  check_value("cnt_irq_ack_o", irq_ack_m, 32'(cnt_irq_ack_o));
  check_value("cnt_rvfi_irqs_o", rvfi_irq_m, 32'(cnt_rvfi_irqs_o));
endtask

// Advance the model to the state after the coming rising edge
task automatic update_model();
  logic next_in_dbg;
  int   cause;
  if (instr_req_i && instr_gnt_i) begin
    pc_q.push_back(instr_req_pc_i);
  end
  if (instr_rvalid_i) begin
    void'(pc_q.pop_front());
  end
  if (data_req_i && data_gnt_i) begin
    store_q.push_back(data_req_is_store_i);
    integ_q.push_back(data_req_integrity_i);
  end
  if (data_rvalid_i) begin
    void'(store_q.pop_front());
    void'(integ_q.pop_front());
  end
  instr_wait_m = instr_req_i && !instr_gnt_i;
  data_wait_m  = data_req_i && !data_gnt_i;

  // Debug flag follows retirements, a completed dret clears it one cycle later
  next_in_dbg = rvfi_valid_i ? rvfi_dbg_mode_i : in_dbg_m;
  if (dret_pend_m) begin
    next_in_dbg = 1'b0;
  end
  dret_pend_m  = !dret_pend_m && rvfi_valid_i && rvfi_is_dret_i && !rvfi_trap_i;
  in_dbg_m     = next_in_dbg;
  fetch_seen_m = fetch_seen_m || fetch_enable_i;

  if (debug_req_i) begin
    rec_dbg_m  = 1'b1;
    dbg_left_m = rvfi_valid_i ? 1 : 2;
  end else if (rvfi_valid_i) begin
    if (dbg_left_m > 0) begin
      dbg_left_m = dbg_left_m - 1;
    end else begin
      rec_dbg_m = 1'b0;
    end
  end

  cause = int'(rvfi_intr_cause_i);
  if (irq_ack_i && irq_ack_m < IRQ_MAX) begin
    irq_ack_m = irq_ack_m + 1;
  end
  if (rvfi_valid_i && rvfi_intr_i && rvfi_irq_m < IRQ_MAX &&
      (cause < `SL_NMI_CAUSE_LO || cause > `SL_NMI_CAUSE_HI)) begin
    rvfi_irq_m = rvfi_irq_m + 1;
  end
endtask

//--- tb/tb_support_logic.sv
// Support logic testbench
// Random bus and retirement stimulus checked against a cycle model
`timescale 1ns/1ps
`include "support_defines.svh"

module tb_support_logic
  import support_pkg::*;
();

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_CYCLES     = 3000;
  // Stimulus length plus a margin for reset
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 1000;

  logic        in_support_if;
  logic        rst_i;
  logic        instr_req_i;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  addr_t       instr_req_pc_i;
  logic        data_req_i;
  logic        data_gnt_i;
  logic        data_rvalid_i;
  logic        data_req_is_store_i;
  logic        data_req_integrity_i;
  logic        rvfi_valid_i;
  logic        rvfi_dbg_mode_i;
  logic        rvfi_is_dret_i;
  logic        rvfi_trap_i;
  logic        rvfi_intr_i;
  logic [10:0] rvfi_intr_cause_i;
  logic        fetch_enable_i;
  logic        debug_req_i;
  logic        irq_ack_i;
  logic        instr_addr_ph_cont_o;
  logic        instr_resp_ph_cont_o;
  ph_cnt_t     instr_outstanding_o;
  logic        data_addr_ph_cont_o;
  logic        data_resp_ph_cont_o;
  ph_cnt_t     data_outstanding_o;
  addr_t       instr_resp_pc_o;
  logic        data_resp_was_store_o;
  logic        data_resp_had_integrity_o;
  logic        first_debug_ins_o;
  logic        first_fetch_o;
  logic        recorded_dbg_req_o;
  irq_cnt_t    cnt_irq_ack_o;
  irq_cnt_t    cnt_rvfi_irqs_o;

  integer seed = 32'h3b13_0082;
  int     cycle_cnt = 0;
  // Stimulus side view of whether the core is in a debug session
  logic   dbg_session;

  support_logic_top u_support_logic_top (.*);

  `include "support_model.svh"

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      end_with_failure($sformatf("[ERROR] %s expected 0x%h actual 0x%h",
                                 name, expected, actual));
    end
  endtask

  // True with a chance of one in n
  function automatic logic one_in(input int n);
    int r;
    r = $random(seed);
    return (r % n) == 0;
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive_stimulus();
    // A request left without grant holds its level and attributes
    if (!(instr_req_i && !instr_gnt_i)) begin
      instr_req_i    = one_in(2);
      instr_req_pc_i = rand_word() & 32'hffff_fffc;
    end
    instr_gnt_i    = one_in(2) && (pc_q.size() < `SL_MAX_OUTSTANDING);
    instr_rvalid_i = one_in(2) && (pc_q.size() > 0);

    if (!(data_req_i && !data_gnt_i)) begin
      data_req_i           = one_in(2);
      data_req_is_store_i  = one_in(2);
      data_req_integrity_i = one_in(2);
    end
    data_gnt_i    = one_in(2) && (store_q.size() < `SL_MAX_OUTSTANDING);
    data_rvalid_i = one_in(2) && (store_q.size() > 0);

    if (!dbg_session && one_in(24)) begin
      dbg_session = 1'b1;
    end
    rvfi_valid_i    = one_in(2);
    rvfi_dbg_mode_i = dbg_session;
    rvfi_is_dret_i  = dbg_session && one_in(6);
    rvfi_trap_i     = one_in(8);
    rvfi_intr_i     = one_in(3);
    // Bias causes around the NMI range edges
    rvfi_intr_cause_i = one_in(3) ? 11'(`SL_NMI_CAUSE_LO - 1 + (rand_word() & 32'h7)) :
                                    11'(rand_word());
    if (rvfi_valid_i && rvfi_is_dret_i && !rvfi_trap_i) begin
      dbg_session = 1'b0;
    end
    fetch_enable_i = one_in(6);
    debug_req_i    = one_in(12);
    irq_ack_i      = one_in(3);
  endtask

  initial begin
    in_support_if = 1'b0;
    forever #10 in_support_if = ~in_support_if;
  end

  always @(posedge in_support_if) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      end_with_failure($sformatf("Timeout: run did not end within %0d cycles",
                                 TIMEOUT_CYCLES));
    end
  end

  initial begin
    rst_i                = 1'b1;
    instr_req_i          = 1'b0;
    instr_gnt_i          = 1'b0;
    instr_rvalid_i       = 1'b0;
    instr_req_pc_i       = '0;
    data_req_i           = 1'b0;
    data_gnt_i           = 1'b0;
    data_rvalid_i        = 1'b0;
    data_req_is_store_i  = 1'b0;
    data_req_integrity_i = 1'b0;
    rvfi_valid_i         = 1'b0;
    rvfi_dbg_mode_i      = 1'b0;
    rvfi_is_dret_i       = 1'b0;
    rvfi_trap_i          = 1'b0;
    rvfi_intr_i          = 1'b0;
    rvfi_intr_cause_i    = '0;
    fetch_enable_i       = 1'b0;
    debug_req_i          = 1'b0;
    irq_ack_i            = 1'b0;
    dbg_session          = 1'b0;
    reset_model();
    repeat (RESET_CYCLES) @(posedge in_support_if);
    #1;
    rst_i = 1'b0;
    // Drive after the edge, check at the falling edge, then advance the model
    repeat (NUM_CYCLES) begin
      drive_stimulus();
      @(negedge in_support_if);
      check_outputs();
      update_model();
      @(posedge in_support_if);
      #1;
    end
    if (irq_ack_m != IRQ_MAX || rvfi_irq_m != IRQ_MAX) begin
      end_with_failure("Interrupt counters never reached saturation during the run");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule : tb_support_logic
